// File: cpuPkg.sv
package cpuPkg;

    localparam int DataWidth = 8;
    localparam int InstrWidth = 16;
    localparam int RegCodeWidth = 3;
    localparam int NumGpRegs = 4;

    // Instruction fields
    localparam int OpMsb = 15;
    localparam int OpLsb = 12;
    localparam int ModeBit = 11;     // 0 direct, 1 through AR
    localparam int RegMsb = 10;      // Destination or memory register
    localparam int RegLsb = 8;
    localparam int Src1Msb = 6;
    localparam int Src1Lsb = 4;
    localparam int Src2Msb = 2;
    localparam int Src2Lsb = 0;
    localparam int ImmMsb = 7;       // Address or immediate
    localparam int ImmLsb = 0;

    typedef logic [DataWidth-1:0] dataT;
    typedef logic [RegCodeWidth-1:0] regCodeT;

    localparam regCodeT ArCode = 3'd4;

    typedef enum logic [3:0] {
        AND = 4'h0,
        OR  = 4'h1,
        NOT = 4'h2,
        ADD = 4'h3,
        SUB = 4'h4,
        LSR = 4'h5,
        LSL = 4'h6,
        INC = 4'h7,
        DEC = 4'h8,
        BRA = 4'h9,
        BNE = 4'hA,
        MOV = 4'hB,
        LD  = 4'hC,
        ST  = 4'hD,
        LDI = 4'hE,
        HLT = 4'hF
    } opcodeT;

    typedef enum logic [2:0] {PassA, And, Or, Not, Add, Sub, Lsr, Lsl} aluOpT;

    typedef enum logic [2:0] {FetchHi, FetchLo, Decode, Execute, MemAccess, Halted} seqStateT;

endpackage

// File: cpuIfs.sv
`timescale 1ns/1ps

// Single memory request towards the APB side
interface memReqIf import cpuPkg::*; ();
    logic req;
    logic write;
    dataT addr;
    dataT wdata;
    dataT rdata;
    logic done;    // Pulses once to end the request

    modport requester (
        output req, write, addr, wdata,
        input  rdata, done
    );

    modport completer (
        input  req, write, addr, wdata,
        output rdata, done
    );
endinterface

interface regFileIf import cpuPkg::*; ();
    regCodeT rdSel1;
    regCodeT rdSel2;
    logic    wrEn;
    regCodeT wrSel;
    dataT    wrData;
    dataT    rdData1;
    dataT    rdData2;
    dataT    arValue;

    modport ctrl (
        output rdSel1, rdSel2, wrEn, wrSel, wrData,
        input  rdData1, rdData2, arValue
    );

    modport regs (
        input  rdSel1, rdSel2, wrEn, wrSel, wrData,
        output rdData1, rdData2, arValue
    );
endinterface

// File: regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic   CLK,
    input  logic   rst_i,
    regFileIf.regs regs
);

    dataT gpReg [NumGpRegs];    // R0 to R3
    dataT arReg;

    function automatic dataT readReg(input regCodeT code);
        dataT value;
        if (code < ArCode) begin
            value = gpReg[code[1:0]];
        end else if (code == ArCode) begin
            value = arReg;
        end else begin
            value = '0;    // Codes 5 to 7
        end
        return value;
    endfunction

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            for (int i = 0; i < NumGpRegs; i++) begin
                gpReg[i] <= '0;
            end
            arReg <= '0;
        end else if (regs.wrEn) begin
            if (regs.wrSel < ArCode) begin
                gpReg[regs.wrSel[1:0]] <= regs.wrData;
            end else if (regs.wrSel == ArCode) begin
                arReg <= regs.wrData;
            end
        end
    end

    assign regs.rdData1 = readReg(regs.rdSel1);
    assign regs.rdData2 = readReg(regs.rdSel2);
    assign regs.arValue = arReg;    // Indirect address

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic  CLK,
    input  logic  rst_i,
    input  aluOpT aluOp_i,
    input  dataT  operandA_i,
    input  dataT  operandB_i,
    input  logic  flagEn_i,
    output dataT  result_o,
    output logic  zero_o
);

    dataT result;
    logic zeroQ;

    always_comb begin
        case (aluOp_i)
            And: begin
                result = operandA_i & operandB_i;
            end
            Or: begin
                result = operandA_i | operandB_i;
            end
            Not: begin
                result = ~operandA_i;
            end
            Add: begin
                result = operandA_i + operandB_i;    // Wraps at 8 bits
            end
            Sub: begin
                result = operandA_i - operandB_i;
            end
            Lsr: begin
                result = operandA_i >> 1;
            end
            Lsl: begin
                result = operandA_i << 1;
            end
            default: begin
                result = operandA_i;    // PassA
            end
        endcase
    end

    // Zero flag for BNE
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            zeroQ <= 1'b0;
        end else if (flagEn_i) begin
            zeroQ <= (result == '0);
        end
    end

    assign result_o = result;
    assign zero_o = zeroQ;

endmodule

// File: apbMaster.sv
`timescale 1ns/1ps

module apbMaster import cpuPkg::*; (
    input  logic       CLK,
    input  logic       rst_i,
    memReqIf.completer mem,
    output dataT       apbAddr_o,
    output logic       apbSel_o,
    output logic       apbEnable_o,
    output logic       apbWrite_o,
    output dataT       apbWdata_o,
    input  dataT       apbRdata_i,
    input  logic       apbReady_i
);

    typedef enum logic [1:0] {Idle, Setup, Access} apbStateT;

    apbStateT state;
    logic accessDone;
    logic startXfer;
    logic writeQ;
    dataT addrQ;
    dataT wdataQ;

    assign accessDone = (state == Access) && apbReady_i;
    // A request seen at completion chains straight into the next setup phase
    assign startXfer = mem.req && ((state == Idle) || accessDone);

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            state <= Idle;
            writeQ <= 1'b0;
        end else if (startXfer) begin
            state <= Setup;
            writeQ <= mem.write;
        end else if (state == Setup) begin
            state <= Access;
        end else if (accessDone) begin
            state <= Idle;
        end
    end

    always_ff @(posedge CLK) begin
        if (startXfer) begin
            addrQ <= mem.addr;
            wdataQ <= mem.wdata;
        end
    end

    assign apbSel_o = (state != Idle);
    assign apbEnable_o = (state == Access);
    assign apbAddr_o = addrQ;
    assign apbWrite_o = writeQ;
    assign apbWdata_o = wdataQ;
    assign mem.done = accessDone;
    assign mem.rdata = apbRdata_i;    // Valid while done is high

endmodule

// File: controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic        CLK,
    input  logic        rst_i,
    memReqIf.requester  mem,
    regFileIf.ctrl      regs,
    output aluOpT       aluOp_o,
    output dataT        operandA_o,
    output dataT        operandB_o,
    output logic        flagEn_o,
    input  dataT        aluResult_i,
    input  logic        zero_i,
    output logic        halted_o
);

    seqStateT state;
    seqStateT nextState;
    dataT pc;
    dataT pcNext;
    logic [InstrWidth-1:0] instr;
    aluOpT aluOpDec;
    aluOpT aluOpQ;
    dataT memAddr;
    opcodeT opcode;
    logic addrMode;
    logic isRegOp;
    regCodeT regField;
    dataT immField;

    assign opcode = opcodeT'(instr[OpMsb:OpLsb]);
    assign addrMode = instr[ModeBit];
    assign regField = instr[RegMsb:RegLsb];
    assign immField = instr[ImmMsb:ImmLsb];
    assign isRegOp = (opcode <= DEC) || (opcode == MOV);

    always_comb begin
        case (opcode)
            AND: aluOpDec = And;
            OR: aluOpDec = Or;
            NOT: aluOpDec = Not;
            ADD, INC: aluOpDec = Add;    // INC and DEC take 1 as operand B
            SUB, DEC: aluOpDec = Sub;
            LSR: aluOpDec = Lsr;
            LSL: aluOpDec = Lsl;
            default: aluOpDec = PassA;
        endcase
    end

    always_comb begin
        nextState = state;
        pcNext = pc;
        case (state)
            FetchHi: begin
                if (mem.done) begin
                    nextState = FetchLo;
                    pcNext = pc + 1'b1;
                end
            end
            FetchLo: begin
                if (mem.done) begin
                    nextState = Decode;
                    pcNext = pc + 1'b1;
                end
            end
            Decode: begin
                nextState = Execute;
            end
            Execute: begin
                nextState = FetchHi;
                case (opcode)
                    LD, ST: nextState = MemAccess;
                    HLT: nextState = Halted;
                    BRA: pcNext = immField;
                    BNE: begin
                        if (!zero_i) begin
                            pcNext = immField;
                        end
                    end
                    default: nextState = FetchHi;
                endcase
            end
            MemAccess: begin
                if (mem.done) begin
                    nextState = FetchHi;
                end
            end
            default: nextState = Halted;    // Stays until reset
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            state <= FetchHi;
            pc <= '0;
        end else begin
            state <= nextState;
            pc <= pcNext;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == FetchHi && mem.done) begin
            instr[InstrWidth-1:DataWidth] <= mem.rdata;
        end
        if (state == FetchLo && mem.done) begin
            instr[DataWidth-1:0] <= mem.rdata;
        end
        if (state == Decode) begin
            aluOpQ <= aluOpDec;
            memAddr <= addrMode ? regs.arValue : immField;
        end
    end

    // Request is raised for the state being entered, so setup starts with it
    assign mem.req = (nextState == FetchHi) || (nextState == FetchLo)
                     || (nextState == MemAccess);
    assign mem.write = (nextState == MemAccess) && (opcode == ST);
    assign mem.addr = (nextState == MemAccess) ? memAddr : pcNext;
    assign mem.wdata = regs.rdData2;

    assign regs.rdSel1 = instr[Src1Msb:Src1Lsb];
    assign regs.rdSel2 = isRegOp ? instr[Src2Msb:Src2Lsb] : regField;
    assign regs.wrSel = regField;
    assign regs.wrEn = ((state == Execute) && (isRegOp || opcode == LDI))
                       || ((state == MemAccess) && (opcode == LD) && mem.done);
    assign regs.wrData = (state == MemAccess) ? mem.rdata
                       : (opcode == LDI) ? immField : aluResult_i;

    assign aluOp_o = aluOpQ;
    assign operandA_o = regs.rdData1;
    assign operandB_o = (opcode == INC || opcode == DEC) ? dataT'(1) : regs.rdData2;
    assign flagEn_o = (state == Execute) && isRegOp;
    assign halted_o = (state == Halted);

endmodule

// File: cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic CLK,
    input  logic rst_i,
    output dataT apbAddr_o,
    output logic apbSel_o,
    output logic apbEnable_o,
    output logic apbWrite_o,
    output dataT apbWdata_o,
    input  dataT apbRdata_i,
    input  logic apbReady_i,
    output logic halted_o
);

    aluOpT aluOp;
    dataT operandA;
    dataT operandB;
    logic flagEn;
    dataT aluResult;
    logic zero;

    memReqIf memBus ();
    regFileIf regBus ();

    controlUnit uControl (
        .CLK         (CLK),
        .rst_i       (rst_i),
        .mem         (memBus.requester),
        .regs        (regBus.ctrl),
        .aluOp_o     (aluOp),
        .operandA_o  (operandA),
        .operandB_o  (operandB),
        .flagEn_o    (flagEn),
        .aluResult_i (aluResult),
        .zero_i      (zero),
        .halted_o    (halted_o)
    );

    regFile uRegFile (
        .CLK   (CLK),
        .rst_i (rst_i),
        .regs  (regBus.regs)
    );

    alu uAlu (
        .CLK        (CLK),
        .rst_i      (rst_i),
        .aluOp_i    (aluOp),
        .operandA_i (operandA),
        .operandB_i (operandB),
        .flagEn_i   (flagEn),
        .result_o   (aluResult),
        .zero_o     (zero)
    );

    apbMaster uApb (
        .CLK         (CLK),
        .rst_i       (rst_i),
        .mem         (memBus.completer),
        .apbAddr_o   (apbAddr_o),
        .apbSel_o    (apbSel_o),
        .apbEnable_o (apbEnable_o),
        .apbWrite_o  (apbWrite_o),
        .apbWdata_o  (apbWdata_o),
        .apbRdata_i  (apbRdata_i),
        .apbReady_i  (apbReady_i)
    );

endmodule

// File: tbCpu.sv
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

    localparam int ResultBase = 'hC0;
    localparam int MaxSteps = 1000;

    logic CLK;
    logic rst = 1'b1;
    logic rstSeen = 1'b0;
    dataT apbAddr;
    logic apbSel;
    logic apbEnable;
    logic apbWrite;
    dataT apbWdata;
    dataT apbRdata = '0;
    logic apbReady = 1'b0;
    logic halted;

    dataT mem [256];        // APB memory model
    dataT initMem [256];    // Image loaded at each reset
    dataT refMem [256];
    dataT aluImage [256];
    dataT aluResults [10];
    dataT refReg [5];       // R0 to R3 and AR
    logic refZero;
    dataT xferAddr [$];
    dataT wrAddr [$];
    dataT wrData [$];
    dataT expAddr [$];
    dataT expData [$];
    int progLen;
    int waitMax = 3;
    int waitLeft = 0;
    longint deadline = 1000;

    cpuTop u_dut (
        .CLK(CLK), .rst_i(rst), .apbAddr_o(apbAddr), .apbSel_o(apbSel),
        .apbEnable_o(apbEnable), .apbWrite_o(apbWrite), .apbWdata_o(apbWdata),
        .apbRdata_i(apbRdata), .apbReady_i(apbReady), .halted_o(halted)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin : apbMemory
        int waits;
        if (apbSel && apbEnable && apbReady) begin
            apbReady <= 1'b0;
            xferAddr.push_back(apbAddr);
            if (apbWrite) begin
                mem[apbAddr] <= apbWdata;
                wrAddr.push_back(apbAddr);
                wrData.push_back(apbWdata);
            end
        end else if (apbSel) begin
            // New wait count at the end of setup
            waits = apbEnable ? waitLeft : int'($urandom % (waitMax + 1));
            if (waits == 0) begin
                apbReady <= 1'b1;
                apbRdata <= mem[apbAddr];
            end else begin
                waitLeft <= waits - 1;
            end
        end
    end

    // Outputs must stay quiet while reset is seen
    always @(posedge CLK) rstSeen <= rst;
    always @(negedge CLK) begin
        if (rstSeen) begin
            compareValue("apbSel_o", apbSel, 0);
            compareValue("apbEnable_o", apbEnable, 0);
            compareValue("apbWrite_o", apbWrite, 0);
            compareValue("halted_o", halted, 0);
        end
    end

    initial begin
        while ($time <= deadline) @(posedge CLK);
        abortRun("Watchdog expired before the CPU halted");
    end

    task automatic compareValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    endtask

    function automatic logic [15:0] regInstr(opcodeT op, regCodeT dst, regCodeT s1, regCodeT s2);
        return {op, 1'b0, dst, 1'b0, s1, 1'b0, s2};
    endfunction

    function automatic logic [15:0] memInstr(opcodeT op, logic mode, regCodeT rg, dataT imm);
        return {op, mode, rg, imm};
    endfunction

    function automatic void clearImage();
        for (int i = 0; i < 256; i++) begin
            initMem[i] = dataT'(i) ^ 8'h3C;
        end
        progLen = 0;
    endfunction

    function automatic void putInstr(input logic [15:0] word);
        initMem[progLen] = word[15:8];    // High byte first
        initMem[progLen + 1] = word[7:0];
        progLen += 2;
    endfunction

    function automatic dataT refRead(input regCodeT code);
        return (code <= ArCode) ? refReg[code] : 8'h00;
    endfunction

    function automatic void refWrite(input regCodeT code, input dataT value);
        if (code <= ArCode) refReg[code] = value;
    endfunction

    // Instruction level model of the image in initMem
    task automatic runModel(output int steps);
        logic [15:0] ins;
        dataT pc;
        dataT a;
        dataT b;
        dataT res;
        dataT addr;
        opcodeT op;
        pc = '0;
        refZero = 1'b0;
        refReg = '{default: '0};
        refMem = initMem;
        expAddr.delete();
        expData.delete();
        op = AND;
        for (steps = 0; op != HLT; steps++) begin
            if (steps == MaxSteps) abortRun("Reference model never reached HLT");
            ins = {refMem[pc], refMem[pc + 8'd1]};
            pc = pc + 8'd2;
            op = opcodeT'(ins[15:12]);
            a = refRead(ins[6:4]);
            b = refRead(ins[2:0]);
            addr = ins[11] ? refReg[4] : ins[7:0];
            if (op <= DEC || op == MOV) begin
                case (op)
                    AND: res = a & b;
                    OR: res = a | b;
                    NOT: res = ~a;
                    ADD: res = a + b;
                    SUB: res = a - b;
                    LSR: res = a >> 1;
                    LSL: res = a << 1;
                    INC: res = a + 8'd1;
                    DEC: res = a - 8'd1;
                    default: res = a;
                endcase
                refZero = (res == 8'h00);
                refWrite(ins[10:8], res);
            end else begin
                case (op)
                    BRA: pc = ins[7:0];
                    BNE: if (!refZero) pc = ins[7:0];
                    LD: refWrite(ins[10:8], refMem[addr]);
                    ST: begin
                        refMem[addr] = refRead(ins[10:8]);
                        expAddr.push_back(addr);
                        expData.push_back(refRead(ins[10:8]));
                    end
                    LDI: refWrite(ins[10:8], ins[7:0]);
                    default: ;    // HLT ends the loop
                endcase
            end
        end
    endtask

    task automatic runProgram(input int waitLimit);
        int steps;
        int haltXfers;
        runModel(steps);
        waitMax = waitLimit;
        deadline = $time + steps * 8 * 4 * 10 + 1000;    // x4 covers wait states
        @(posedge CLK);
        rst <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] <= initMem[i];
        end
        repeat (16) @(posedge CLK);
        rst <= 1'b0;
        xferAddr.delete();
        wrAddr.delete();
        wrData.delete();
        while (!halted) @(negedge CLK);
        haltXfers = xferAddr.size();
        repeat (10) @(negedge CLK);
        compareValue("APB transfers after halt", xferAddr.size(), haltXfers);
        compareValue("halted_o", halted, 1);
        compareValue("number of APB writes", wrAddr.size(), expAddr.size());
        foreach (expAddr[i]) begin
            compareValue("apbAddr_o", wrAddr[i], expAddr[i]);
            compareValue("apbWdata_o", wrData[i], expData[i]);
        end
        for (int i = 0; i < 256; i++) begin
            compareValue($sformatf("mem[0x%0h]", i), mem[i], refMem[i]);
        end
    endtask

    task automatic haltAfterReset();
        clearImage();
        putInstr(memInstr(HLT, 1'b0, 3'd0, 8'h00));
        runProgram(3);
        compareValue("APB transfers", xferAddr.size(), 2);    // Both bytes of HLT
        compareValue("first apbAddr_o", xferAddr[0], 0);
        compareValue("second apbAddr_o", xferAddr[1], 1);
    endtask

    task automatic storeDirectAndIndirect();
        dataT vals [4];
        clearImage();
        for (int r = 0; r < 4; r++) begin
            vals[r] = dataT'($urandom);
            putInstr(memInstr(LDI, 1'b0, regCodeT'(r), vals[r]));
        end
        for (int r = 0; r < 4; r++) begin
            putInstr(memInstr(ST, 1'b0, regCodeT'(r), dataT'(8'h80 + r)));
        end
        putInstr(memInstr(LDI, 1'b0, 3'd0, 8'h90));
        putInstr(regInstr(MOV, ArCode, 3'd0, 3'd0));
        putInstr(memInstr(ST, 1'b1, 3'd3, 8'h00));    // Field ignored in mode 1
        putInstr(memInstr(LDI, 1'b0, 3'd1, 8'hA7));
        putInstr(regInstr(MOV, ArCode, 3'd1, 3'd0));
        putInstr(memInstr(ST, 1'b1, 3'd2, 8'h00));
        putInstr(memInstr(HLT, 1'b0, 3'd0, 8'h00));
        runProgram(3);
        compareValue("mem[0x90]", mem[8'h90], vals[3]);
        compareValue("mem[0xA7]", mem[8'hA7], vals[2]);
    endtask

    task automatic aluOperations();
        opcodeT ops [10];
        ops = '{AND, OR, NOT, ADD, SUB, LSR, LSL, INC, DEC, MOV};
        clearImage();
        putInstr(memInstr(LDI, 1'b0, 3'd0, dataT'($urandom)));
        putInstr(memInstr(LDI, 1'b0, 3'd1, dataT'($urandom)));
        foreach (ops[k]) begin
            putInstr(regInstr(ops[k], 3'd2, 3'd0, 3'd1));
            putInstr(memInstr(ST, 1'b0, 3'd2, dataT'(ResultBase + k)));
        end
        putInstr(memInstr(HLT, 1'b0, 3'd0, 8'h00));
        aluImage = initMem;
        runProgram(3);
        foreach (aluResults[k]) aluResults[k] = mem[ResultBase + k];
    endtask

    task automatic aluUnderBackPressure();
        initMem = aluImage;
        runProgram(7);
        foreach (aluResults[k]) begin
            compareValue($sformatf("mem[0x%0h]", ResultBase + k), mem[ResultBase + k],
                         aluResults[k]);
        end
    endtask

    task automatic loadDirectAndIndirect();
        clearImage();
        initMem[8'hE0] = dataT'($urandom);
        initMem[8'hE1] = dataT'($urandom);
        putInstr(memInstr(LD, 1'b0, 3'd1, 8'hE0));
        putInstr(memInstr(LDI, 1'b0, 3'd0, 8'hE1));
        putInstr(regInstr(MOV, ArCode, 3'd0, 3'd0));
        putInstr(memInstr(LD, 1'b1, 3'd2, 8'h00));
        putInstr(memInstr(ST, 1'b0, 3'd1, 8'hF0));
        putInstr(memInstr(ST, 1'b0, 3'd2, 8'hF1));
        putInstr(memInstr(HLT, 1'b0, 3'd0, 8'h00));
        runProgram(3);
        compareValue("mem[0xF0]", mem[8'hF0], initMem[8'hE0]);
        compareValue("mem[0xF1]", mem[8'hF1], initMem[8'hE1]);
    endtask

    task automatic branchAndLoop();
        dataT count;
        dataT loopAddr;
        count = dataT'(1 + $urandom % 20);
        clearImage();
        putInstr(memInstr(LDI, 1'b0, 3'd0, 8'h5A));
        putInstr(memInstr(BRA, 1'b0, 3'd0, dataT'(progLen + 4)));
        putInstr(memInstr(ST, 1'b0, 3'd0, 8'hD0));    // Skipped
        putInstr(memInstr(LDI, 1'b0, 3'd1, count));
        putInstr(memInstr(LDI, 1'b0, 3'd2, 8'h00));
        loopAddr = dataT'(progLen);
        putInstr(regInstr(INC, 3'd2, 3'd2, 3'd0));
        putInstr(regInstr(DEC, 3'd1, 3'd1, 3'd0));
        putInstr(memInstr(BNE, 1'b0, 3'd0, loopAddr));
        putInstr(memInstr(ST, 1'b0, 3'd2, 8'hD1));
        putInstr(memInstr(ST, 1'b0, 3'd1, 8'hD2));
        putInstr(memInstr(HLT, 1'b0, 3'd0, 8'h00));
        runProgram(3);
        compareValue("mem[0xD0]", mem[8'hD0], initMem[8'hD0]);
        compareValue("mem[0xD1]", mem[8'hD1], count);
        compareValue("mem[0xD2]", mem[8'hD2], 0);
    endtask

    initial begin
        void'($urandom(32'hc1aa_de65));
        haltAfterReset();
        storeDirectAndIndirect();
        aluOperations();
        aluUnderBackPressure();
        loadDirectAndIndirect();
        branchAndLoop();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: filelist.f
cpuPkg.sv
cpuIfs.sv
regFile.sv
alu.sv
apbMaster.sv
controlUnit.sv
cpuTop.sv
tbCpu.sv

// File: run.sh
#!/bin/sh
verilator --binary -Wno-fatal -f filelist.f --top-module tbCpu \
    && ./obj_dir/VtbCpu \
    || exit 1
